// File: msx_glue_pkg.sv
/*
   MSX glue shared types
   Status word layout, live flags, video and DDR3 bundles, register map
*/
package msx_glue_pkg;

   // ==============================
   // APB register map
   // ==============================
   parameter int apb_addr_w = 12;

   parameter logic [apb_addr_w-1:0] reg_status = 12'h000;
   parameter logic [apb_addr_w-1:0] reg_flags  = 12'h004;

   // ==============================
   // Menu and board constants
   // ==============================
   // Download index of a cassette image
   parameter logic [15:0] cas_ioctl_index = 16'd5;

   // Aspect field value for plain 4:3
   parameter logic [1:0] ar_original = 2'd0;

   // 1080p output gets a 216-line crop
   parameter logic [11:0] crop_216p   = 12'd216;
   parameter logic [11:0] hdmi_1080_w = 12'd1920;
   parameter logic [11:0] hdmi_1080_h = 12'd1080;

   // Scandoubler effect code that selects HQ2x
   parameter logic [2:0] fx_hq2x = 3'd1;

   // SD activity hold, in clock cycles
   parameter int act_hold_default = 1000000;

   // ==============================
   // Status word
   // ==============================
   typedef struct packed {
      logic [9:0] rsvd_31_22;
      logic       user_reset;
      logic [6:0] rsvd_20_14;
      logic       cas_src_adc;
      logic       mount_reset;
      logic       rsvd_11;
      logic       detach_reset;
      logic       tape_rewind;
      logic [2:0] video_scale;
      logic [2:0] scandbl_fx;
      logic [1:0] aspect;
      logic       cold_reset;
   } status_fields_t;

   // Raw view for APB, field view for the consumers
   typedef union packed {
      logic [31:0]    raw;
      status_fields_t f;
   } status_word_u;

   // Read-only flags, hard_reset in bit 0
   typedef struct packed {
      logic reserved;
      logic cas_downloading;
      logic play;
      logic cas_load;
      logic sd_act;
      logic vsd_sel;
      logic core_reset;
      logic hard_reset;
   } live_flags_t;

   typedef struct packed {
      logic [11:0] arx;
      logic [11:0] ary;
      logic [11:0] crop_size;
      logic [1:0]  vga_sl;
      logic [2:0]  scale_mode;
      logic        hq2x;
   } video_ctrl_t;

   typedef struct packed {
      logic [27:0] addr;
      logic        rd;
   } ddr3_req_t;

endpackage

// File: msx_status_regs.sv
/*
   APB status registers
   Holds the menu status word and returns the live flags read-only
*/
`timescale 1ns/10ps

module msx_status_regs (
   input  logic                                clock_bus,
   input  logic                                rst,
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [msx_glue_pkg::apb_addr_w-1:0] paddr,
   input  logic [31:0]                         pwdata,
   input  logic [3:0]                          pstrb,
   input  msx_glue_pkg::live_flags_t           flags,
   output logic [31:0]                         prdata,
   output logic                                pready,
   output logic                                pslverr,
   output msx_glue_pkg::status_word_u          status_o
);

   logic hit_status;
   logic hit_flags;
   logic access;
   logic bad_access;
   logic wr_status;

   // ==============================
   // Address decode
   // ==============================
   assign hit_status = (paddr == msx_glue_pkg::reg_status);
   assign hit_flags  = (paddr == msx_glue_pkg::reg_flags);
   assign access     = psel & penable;

   // Flags register is read-only, everything else is unmapped
   assign bad_access = ~(hit_status | hit_flags) | (hit_flags & pwrite);
   assign wr_status  = access & pwrite & hit_status;

   // No wait states
   assign pready  = 1'b1;
   assign pslverr = access & bad_access;

   // ==============================
   // Status word storage
   // ==============================
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         status_o.raw <= '0;
      end else if (wr_status) begin
         for (int i = 0; i < 4; i++) begin
            if (pstrb[i]) begin
               status_o.raw[8*i +: 8] <= pwdata[8*i +: 8];
            end
         end
      end
   end

   // Read data
   always_comb begin
      prdata = '0;
      if (psel) begin
         if (hit_status) begin
            prdata = status_o.raw;
         end else if (hit_flags) begin
            prdata = 32'(flags);
         end
      end
   end

endmodule

// File: msx_reset_ctrl.sv
/*
   Reset generation
   Registered hard and core resets from board, menu, loader and mount events
*/
`timescale 1ns/10ps

module msx_reset_ctrl (
   input  logic                       clock_bus,
   input  logic                       rst,
   input  logic                       board_reset,
   input  logic                       upload_reset,
   input  logic                       fdc_present,
   input  logic                       sd_img_mounted,
   input  msx_glue_pkg::status_word_u status,
   output logic                       hard_reset,
   output logic                       core_reset
);

   logic hard_src;
   logic mount_src;
   logic core_src;

   assign hard_src  = board_reset | status.f.cold_reset | upload_reset;

   // Reset after mount only matters with a floppy controller fitted
   assign mount_src = status.f.mount_reset & sd_img_mounted & fdc_present;

   assign core_src  = hard_src | status.f.detach_reset | status.f.user_reset | mount_src;

   always_ff @(posedge clock_bus) begin
      if (rst) begin
         hard_reset <= 1'b1;
         core_reset <= 1'b1;
      end else begin
         hard_reset <= hard_src;
         // Every hard reset source also resets the core
         core_reset <= core_src;
      end
   end

endmodule

// File: msx_sd_activity.sv
/*
   SD card select and activity
   Steers SPI to the physical card or the image, holds the disk LEDs on
*/
`timescale 1ns/10ps

module msx_sd_activity #(
   parameter int act_hold_cycles = msx_glue_pkg::act_hold_default
) (
   input  logic        clock_bus,
   input  logic        rst,
   input  logic        sd_img_mounted,
   input  logic [63:0] sd_img_size,
   input  logic        spi_sck,
   input  logic        spi_mosi,
   input  logic        vsd_miso,
   input  logic        sd_miso,
   output logic        sd_sck,
   output logic        sd_mosi,
   output logic        sd_cs,
   output logic        core_miso,
   output logic        vsd_sel,
   output logic        sd_act,
   output logic        led_user,
   output logic [1:0]  led_disk
);

   localparam int cnt_w = $clog2(act_hold_cycles + 1);
   localparam logic [cnt_w-1:0] hold_max = cnt_w'(act_hold_cycles);

   logic [cnt_w-1:0] act_cnt;
   logic             old_mosi;
   logic             old_miso;
   logic             bus_toggle;

   // ==============================
   // Card select
   // ==============================
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         vsd_sel <= 1'b0;
      end else if (sd_img_mounted) begin
         // Zero-size mount hands the bus back to the real card
         vsd_sel <= |sd_img_size;
      end
   end

   // Physical card is deselected and quiet while the image is in use
   assign sd_cs     = vsd_sel;
   assign sd_sck    = spi_sck & ~vsd_sel;
   assign sd_mosi   = spi_mosi & ~vsd_sel;
   assign core_miso = vsd_sel ? vsd_miso : sd_miso;

   // ==============================
   // Activity hold timer
   // ==============================
   always_ff @(posedge clock_bus) begin
      old_mosi <= spi_mosi;
      old_miso <= core_miso;
   end

   assign bus_toggle = (old_mosi ^ spi_mosi) | (old_miso ^ core_miso);

   always_ff @(posedge clock_bus) begin
      if (rst) begin
         act_cnt <= hold_max;
      end else if (bus_toggle) begin
         act_cnt <= '0;
      end else if (act_cnt < hold_max) begin
         act_cnt <= act_cnt + 1'b1;
      end
   end

   assign sd_act   = (act_cnt < hold_max);
   assign led_user = vsd_sel & sd_act;
   assign led_disk = {1'b1, ~vsd_sel & sd_act};

endmodule

// File: msx_tape_ctrl.sv
/*
   Cassette control
   Load detection, play and rewind, tape source and DDR3 read arbitration
*/
`timescale 1ns/10ps

module msx_tape_ctrl (
   input  logic                       clock_bus,
   input  logic                       rst,
   input  msx_glue_pkg::status_word_u status,
   input  logic                       core_reset,
   input  logic                       ioctl_download,
   input  logic [15:0]                ioctl_index,
   input  logic                       tape_motor,
   input  logic                       cas_bit,
   input  logic                       adc_bit,
   input  logic                       adc_active,
   input  msx_glue_pkg::ddr3_req_t    download_req,
   input  logic                       download_request,
   input  msx_glue_pkg::ddr3_req_t    cas_req,
   output logic                       tape_in,
   output logic                       play,
   output logic                       rewind,
   output logic                       cas_load,
   output logic                       cas_downloading,
   output msx_glue_pkg::ddr3_req_t    ddr3_req
);

   logic cas_dl_q;

   assign cas_downloading = ioctl_download & (ioctl_index == msx_glue_pkg::cas_ioctl_index);

   // ==============================
   // Load detection
   // ==============================
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         cas_dl_q <= 1'b0;
         cas_load <= 1'b0;
      end else begin
         cas_dl_q <= cas_downloading;
         // End of a cassette download arms the player
         if (cas_dl_q & ~cas_downloading) begin
            cas_load <= 1'b1;
         end
      end
   end

   // Motor line is active low
   assign play   = ~tape_motor & cas_load;
   assign rewind = status.f.tape_rewind | cas_downloading | core_reset;

   // ADC input counts only once the sampler has locked
   assign tape_in = status.f.cas_src_adc ? (adc_bit & adc_active) : cas_bit;

   // ==============================
   // DDR3 read port
   // ==============================
   // ROM downloader always wins
   assign ddr3_req = download_request ? download_req : cas_req;

endmodule

// File: msx_video_cfg.sv
/*
   Video settings decode
   Aspect, scanlines, HQ2x, scaler mode and the 1080p crop
*/
`timescale 1ns/10ps

module msx_video_cfg (
   input  logic                       clock_bus,
   input  logic                       rst,
   input  msx_glue_pkg::status_word_u status,
   input  logic [11:0]                hdmi_width,
   input  logic [11:0]                hdmi_height,
   input  logic                       forced_scandoubler,
   output msx_glue_pkg::video_ctrl_t  video_ctrl,
   output logic                       scandoubler
);

   logic [1:0] aspect;
   logic [2:0] fx;
   logic [2:0] sl;
   logic       is_4x3;
   logic       en216p;

   assign aspect = status.f.aspect;
   assign fx     = status.f.scandbl_fx;
   assign is_4x3 = (aspect == msx_glue_pkg::ar_original);

   // Effect 0 is none, 1 is HQ2x, CRT levels follow
   assign sl          = (fx != 3'd0) ? fx - 3'd1 : 3'd0;
   assign scandoubler = forced_scandoubler | (fx != 3'd0);

   // ==============================
   // 1080p crop
   // ==============================
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         en216p <= 1'b0;
      end else begin
         en216p <= (hdmi_width == msx_glue_pkg::hdmi_1080_w) &&
                   (hdmi_height == msx_glue_pkg::hdmi_1080_h) && !scandoubler;
      end
   end

   always_comb begin
      // Custom ratios are passed as an index with ary zero
      video_ctrl.arx        = is_4x3 ? 12'd4 : {10'd0, aspect - 2'd1};
      video_ctrl.ary        = is_4x3 ? 12'd3 : 12'd0;
      video_ctrl.crop_size  = en216p ? msx_glue_pkg::crop_216p : 12'd0;
      video_ctrl.vga_sl     = sl[1:0];
      video_ctrl.scale_mode = status.f.video_scale;
      video_ctrl.hq2x       = (fx == msx_glue_pkg::fx_hq2x);
   end

endmodule

// File: msx_glue_top.sv
/*
   MSX glue top level
   Status registers feeding the reset, SD, tape and video control blocks
*/
`timescale 1ns/10ps

module msx_glue_top #(
   parameter int act_hold_cycles = msx_glue_pkg::act_hold_default
) (
   input  logic                                clock_bus,
   input  logic                                rst,
   input  logic                                board_reset,
   input  logic                                upload_reset,
   input  logic                                fdc_present,

   // APB
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [msx_glue_pkg::apb_addr_w-1:0] paddr,
   input  logic [31:0]                         pwdata,
   input  logic [3:0]                          pstrb,
   output logic [31:0]                         prdata,
   output logic                                pready,
   output logic                                pslverr,

   // SD card
   input  logic                                sd_img_mounted,
   input  logic [63:0]                         sd_img_size,
   input  logic                                spi_sck,
   input  logic                                spi_mosi,
   input  logic                                vsd_miso,
   input  logic                                sd_miso,
   output logic                                sd_sck,
   output logic                                sd_mosi,
   output logic                                sd_cs,
   output logic                                core_miso,
   output logic                                led_user,
   output logic [1:0]                          led_disk,

   // Tape and DDR3
   input  logic                                ioctl_download,
   input  logic [15:0]                         ioctl_index,
   input  logic                                tape_motor,
   input  logic                                cas_bit,
   input  logic                                adc_bit,
   input  logic                                adc_active,
   output logic                                tape_in,
   output logic                                play,
   output logic                                rewind,
   input  msx_glue_pkg::ddr3_req_t             download_req,
   input  logic                                download_request,
   input  msx_glue_pkg::ddr3_req_t             cas_req,
   output msx_glue_pkg::ddr3_req_t             ddr3_req,

   // Video
   input  logic [11:0]                         hdmi_width,
   input  logic [11:0]                         hdmi_height,
   input  logic                                forced_scandoubler,
   output msx_glue_pkg::video_ctrl_t           video_ctrl,
   output logic                                scandoubler,

   // Resets
   output logic                                core_reset,
   output logic                                hard_reset
);

   msx_glue_pkg::status_word_u status;
   msx_glue_pkg::live_flags_t  flags;
   logic                       vsd_sel;
   logic                       sd_act;
   logic                       cas_load;
   logic                       cas_downloading;

   // Live flags gathered for reg_flags
   assign flags = '{
      reserved:        1'b0,
      cas_downloading: cas_downloading,
      play:            play,
      cas_load:        cas_load,
      sd_act:          sd_act,
      vsd_sel:         vsd_sel,
      core_reset:      core_reset,
      hard_reset:      hard_reset
   };

   // ==============================
   // Blocks
   // ==============================
   msx_status_regs i_status_regs (
      .status_o (status),
      .*
   );

   msx_reset_ctrl i_reset_ctrl (
      .*
   );

   msx_sd_activity #(
      .act_hold_cycles (act_hold_cycles)
   ) i_sd_activity (
      .*
   );

   msx_tape_ctrl i_tape_ctrl (
      .*
   );

   msx_video_cfg i_video_cfg (
      .*
   );

endmodule

// File: msx_glue_assertions.sv
/*
   MSX glue protocol checks
   APB zero-wait access, status word stability and reset ordering
*/
`timescale 1ns/10ps

module msx_glue_assertions (
   input logic                                clock_bus,
   input logic                                rst,
   input logic                                psel,
   input logic                                penable,
   input logic                                pwrite,
   input logic [msx_glue_pkg::apb_addr_w-1:0] paddr,
   input logic                                pready,
   input logic [31:0]                         status_raw,
   input logic                                hard_reset,
   input logic                                core_reset
);

   logic status_wr;
   int   fail_cnt = 0;

   assign status_wr = psel & penable & pwrite & (paddr == msx_glue_pkg::reg_status);

   // Every access phase completes at once
   pready_in_access: assert property (
      @(posedge clock_bus) disable iff (rst) (psel && penable) |-> pready
   ) else begin
      $error("pready low during an APB access phase");
      fail_cnt++;
   end

   // Only a status write may change the word
   status_hold: assert property (
      @(posedge clock_bus) disable iff (rst) !status_wr |=> $stable(status_raw)
   ) else begin
      $error("status word changed without an APB write");
      fail_cnt++;
   end

   hard_in_core: assert property (
      @(posedge clock_bus) disable iff (rst) hard_reset |-> core_reset
   ) else begin
      $error("hard reset active without core reset");
      fail_cnt++;
   end

endmodule

// File: tb_msx_glue.sv
/*
   MSX glue testbench
   Replays the stimulus file over APB and side ports, compares DUT outputs
*/
`timescale 1ns/10ps

module tb_msx_glue;

   // Reserved bits of the status word, randomized by the rsv operation
   localparam logic [31:0] rsvd_mask = 32'hffdf_c800;

   logic clock_bus;
   logic rst;
   logic board_reset;
   logic upload_reset;
   logic fdc_present;
   logic psel;
   logic penable;
   logic pwrite;
   logic [msx_glue_pkg::apb_addr_w-1:0] paddr;
   logic [31:0] pwdata;
   logic [3:0]  pstrb;
   logic [31:0] prdata;
   logic pready;
   logic pslverr;
   logic sd_img_mounted;
   logic [63:0] sd_img_size;
   logic spi_sck;
   logic spi_mosi;
   logic vsd_miso;
   logic sd_miso;
   logic sd_sck;
   logic sd_mosi;
   logic sd_cs;
   logic core_miso;
   logic led_user;
   logic [1:0] led_disk;
   logic ioctl_download;
   logic [15:0] ioctl_index;
   logic tape_motor;
   logic cas_bit;
   logic adc_bit;
   logic adc_active;
   logic tape_in;
   logic play;
   logic rewind;
   msx_glue_pkg::ddr3_req_t download_req;
   logic download_request;
   msx_glue_pkg::ddr3_req_t cas_req;
   msx_glue_pkg::ddr3_req_t ddr3_req;
   logic [11:0] hdmi_width;
   logic [11:0] hdmi_height;
   logic forced_scandoubler;
   msx_glue_pkg::video_ctrl_t video_ctrl;
   logic scandoubler;
   logic core_reset;
   logic hard_reset;

   int err_cnt = 0;
   int check_cnt = 0;
   int line_cnt = 0;
   int cycle_cnt = 0;
   int cycle_limit = 0;

   msx_glue_top #(
      .act_hold_cycles (16)
   ) i_dut (
      .*
   );

   bind msx_status_regs msx_glue_assertions i_apb_sva (
      .clock_bus (clock_bus), .rst (rst), .psel (psel), .penable (penable),
      .pwrite (pwrite), .paddr (paddr), .pready (pready), .status_raw (status_o),
      .hard_reset (1'b0), .core_reset (1'b0)
   );

   bind msx_reset_ctrl msx_glue_assertions i_reset_sva (
      .clock_bus (clock_bus), .rst (rst), .psel (1'b0), .penable (1'b0),
      .pwrite (1'b0), .paddr ('0), .pready (1'b1), .status_raw (32'd0),
      .hard_reset (hard_reset), .core_reset (core_reset)
   );

   initial begin
      clock_bus = 1'b0;
      forever #5 clock_bus = ~clock_bus;
   end

   // ==============================
   // APB master and side inputs
   // ==============================
   task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strb, output logic [31:0] rdata,
                           output logic err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      pstrb   = strb;
      @(negedge clock_bus);
      penable = 1'b1;
      @(posedge clock_bus);
      while (!pready) @(posedge clock_bus);
      rdata = prdata;
      err   = pslverr;
      @(negedge clock_bus);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic drive_input(input string name, input logic [63:0] val);
      case (name)
         "board_reset":        board_reset = val[0];
         "upload_reset":       upload_reset = val[0];
         "fdc_present":        fdc_present = val[0];
         "spi_sck":            spi_sck = val[0];
         "spi_mosi":           spi_mosi = val[0];
         "vsd_miso":           vsd_miso = val[0];
         "sd_miso":            sd_miso = val[0];
         "ioctl_download":     ioctl_download = val[0];
         "ioctl_index":        ioctl_index = val[15:0];
         "tape_motor":         tape_motor = val[0];
         "cas_bit":            cas_bit = val[0];
         "adc_bit":            adc_bit = val[0];
         "adc_active":         adc_active = val[0];
         "download_req":       download_req = val[28:0];
         "download_request":   download_request = val[0];
         "cas_req":            cas_req = val[28:0];
         "hdmi_width":         hdmi_width = val[11:0];
         "hdmi_height":        hdmi_height = val[11:0];
         "forced_scandoubler": forced_scandoubler = val[0];
         default: begin
            $display("Stimulus file names an unknown input %s", name);
            err_cnt++;
         end
      endcase
   endtask

   // ==============================
   // Compare tasks
   // ==============================
   task automatic check_prdata(input logic [31:0] got, input logic [31:0] exp);
      check_cnt++;
      if (got !== exp) begin
         $display("ERR %0t: prdata got %h expected %h", $time, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_pslverr(input logic got, input logic exp);
      check_cnt++;
      if (got !== exp) begin
         $display("ERR %0t: pslverr got %b expected %b", $time, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_flags(input msx_glue_pkg::live_flags_t got,
                              input msx_glue_pkg::live_flags_t exp);
      check_cnt++;
      if (got !== exp) begin
         $display("ERR %0t: live flags got %h expected %h", $time, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_video(input msx_glue_pkg::video_ctrl_t got,
                              input msx_glue_pkg::video_ctrl_t exp);
      check_cnt++;
      if (got !== exp) begin
         $display("ERR %0t: video_ctrl got %h expected %h", $time, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_ddr3(input msx_glue_pkg::ddr3_req_t got,
                             input msx_glue_pkg::ddr3_req_t exp);
      check_cnt++;
      if (got !== exp) begin
         $display("ERR %0t: ddr3_req got %h expected %h", $time, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_pin(input string name, input logic [1:0] exp);
      logic [1:0] got;
      logic       known;

      known = 1'b1;
      got   = 2'b00;
      case (name)
         "core_reset":  got = {1'b0, core_reset};
         "hard_reset":  got = {1'b0, hard_reset};
         "sd_cs":       got = {1'b0, sd_cs};
         "sd_sck":      got = {1'b0, sd_sck};
         "sd_mosi":     got = {1'b0, sd_mosi};
         "core_miso":   got = {1'b0, core_miso};
         "led_user":    got = {1'b0, led_user};
         "led_disk":    got = led_disk;
         "tape_in":     got = {1'b0, tape_in};
         "play":        got = {1'b0, play};
         "rewind":      got = {1'b0, rewind};
         "scandoubler": got = {1'b0, scandoubler};
         default:       known = 1'b0;
      endcase
      check_cnt++;
      if (!known) begin
         $display("Stimulus file asks for an unknown output %s", name);
         err_cnt++;
      end else if (got !== exp) begin
         $display("ERR %0t: %s got %h expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   // Watchdog, limit set once the stimulus file is counted
   initial begin
      wait (cycle_limit > 0);
      while (cycle_cnt < cycle_limit) begin
         @(posedge clock_bus);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles, the stimulus did not finish", cycle_cnt);
      $display("sim failed");
      $finish;
   end

   // ==============================
   // Stimulus replay
   // ==============================
   initial begin
      int          fd;
      int          n;
      string       line;
      string       op;
      string       name;
      logic [63:0] a;
      logic [63:0] b;
      logic [63:0] c;
      logic [63:0] d;
      logic [31:0] rdata;
      logic [31:0] wdata;
      logic        err;

      void'($urandom(53));
      rst = 1'b1;
      {board_reset, upload_reset, fdc_present} = '0;
      {psel, penable, pwrite, paddr, pwdata, pstrb} = '0;
      {sd_img_mounted, sd_img_size, spi_sck, spi_mosi, vsd_miso, sd_miso} = '0;
      {ioctl_download, ioctl_index, tape_motor, cas_bit, adc_bit, adc_active} = '0;
      {download_req, download_request, cas_req} = '0;
      {hdmi_width, hdmi_height, forced_scandoubler} = '0;

      fd = $fopen("msx_glue_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file msx_glue_input.txt");
         err_cnt++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0) line_cnt++;
         end
         $fclose(fd);
         cycle_limit = 20 * line_cnt + 100;
         fd = $fopen("msx_glue_input.txt", "r");
      end

      repeat (4) @(posedge clock_bus);
      @(negedge clock_bus);
      rst = 1'b0;

      while (fd != 0 && !$feof(fd)) begin
         line = "";
         op   = "";
         void'($fgets(line, fd));
         n = $sscanf(line, "%s", op);
         if (n > 0 && op.getc(0) != "#") begin
            case (op)
               "wait": begin
                  n = $sscanf(line, "%s %d", op, a);
                  repeat (a) @(negedge clock_bus);
               end
               "wr": begin
                  n = $sscanf(line, "%s %h %h %h %h", op, a, b, c, d);
                  apb_xfer(1'b1, a[11:0], b[31:0], c[3:0], rdata, err);
                  check_pslverr(err, d[0]);
               end
               "rd": begin
                  n = $sscanf(line, "%s %h %h %h", op, a, b, c);
                  apb_xfer(1'b0, a[11:0], 32'd0, 4'd0, rdata, err);
                  check_prdata(rdata, b[31:0]);
                  check_pslverr(err, c[0]);
               end
               "rsv": begin
                  n = $sscanf(line, "%s %h", op, a);
                  wdata = (a[31:0] & ~rsvd_mask) | ($urandom & rsvd_mask);
                  apb_xfer(1'b1, msx_glue_pkg::reg_status, wdata, 4'hf, rdata, err);
                  check_pslverr(err, 1'b0);
                  apb_xfer(1'b0, msx_glue_pkg::reg_status, 32'd0, 4'd0, rdata, err);
                  check_prdata(rdata, wdata);
               end
               "flags": begin
                  n = $sscanf(line, "%s %h", op, a);
                  // Reset pins carry the same state as the low flag bits
                  check_pin("hard_reset", {1'b0, a[0]});
                  check_pin("core_reset", {1'b0, a[1]});
                  apb_xfer(1'b0, msx_glue_pkg::reg_flags, 32'd0, 4'd0, rdata, err);
                  check_flags(rdata[7:0], a[7:0]);
                  check_prdata(rdata, {24'd0, a[7:0]});
                  check_pslverr(err, 1'b0);
               end
               "mount": begin
                  n = $sscanf(line, "%s %h", op, a);
                  sd_img_size    = a;
                  sd_img_mounted = 1'b1;
                  @(negedge clock_bus);
                  sd_img_mounted = 1'b0;
               end
               "set": begin
                  n = $sscanf(line, "%s %s %h", op, name, a);
                  drive_input(name, a);
               end
               "pin": begin
                  n = $sscanf(line, "%s %s %h", op, name, a);
                  check_pin(name, a[1:0]);
                  // Card select also decides the SPI data routing
                  if (name == "sd_cs") begin
                     check_pin("sd_mosi", {1'b0, spi_mosi & ~a[0]});
                     check_pin("core_miso", {1'b0, a[0] ? vsd_miso : sd_miso});
                  end
               end
               "video": begin
                  n = $sscanf(line, "%s %h", op, a);
                  check_video(video_ctrl, a[41:0]);
               end
               "ddr3": begin
                  n = $sscanf(line, "%s %h", op, a);
                  check_ddr3(ddr3_req, a[28:0]);
               end
               default: begin
                  $display("Stimulus file has an unknown operation %s", op);
                  err_cnt++;
               end
            endcase
         end
      end
      if (fd != 0) $fclose(fd);

      err_cnt += i_dut.i_status_regs.i_apb_sva.fail_cnt;
      err_cnt += i_dut.i_reset_ctrl.i_reset_sva.fail_cnt;

      $display("Checks run %0d, errors %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: msx_glue_input.txt
# Columns: op arg1 arg2 arg3 arg4, numbers in hex except wait counts
# wr addr data strb err | rd addr data err | rsv base | set or pin name value
# flags value | video value | ddr3 value | mount size | wait cycles
wait 2
flags 00
rsv 00000000
wr 000 ff800000 f 0
wr 000 0000ffff 8 0
rd 000 00800000 0
wr 004 ffffffff f 1
wr 100 ffffffff f 1
rd 100 00000000 1
rd 000 00800000 0
wr 000 00200000 f 0
wait 2
flags 02
wr 000 00000001 f 0
wait 2
flags 03
wr 000 00001000 f 0
wait 2
flags 00
set fdc_present 1
mount 0
pin core_reset 1
wait 1
pin core_reset 0
set fdc_present 0
mount 0
pin core_reset 0
wr 000 00000000 f 0
mount 1000
pin sd_cs 1
set spi_sck 1
wait 1
pin sd_sck 0
flags 04
set spi_mosi 1
wait 1
pin led_user 1
pin led_disk 2
wait 15
pin led_user 1
wait 2
pin led_user 0
mount 0
pin sd_cs 0
pin sd_sck 1
set ioctl_index 5
set ioctl_download 1
wait 1
pin rewind 1
flags 40
set ioctl_download 0
wait 2
flags 30
pin rewind 0
set tape_motor 1
wait 1
pin play 0
set cas_bit 1
wait 1
pin tape_in 1
wr 000 00002000 f 0
pin tape_in 0
set adc_bit 1
wait 1
pin tape_in 0
set adc_active 1
wait 1
pin tape_in 1
set download_req 02468acf
set cas_req 13579bde
set download_request 1
wait 1
ddr3 02468acf
set download_request 0
wait 1
ddr3 13579bde
wr 000 00000000 f 0
set hdmi_width 780
set hdmi_height 438
wait 2
video 1000c3600
wr 000 0000015c f 0
wait 1
video 4000002a
wr 000 00000008 f 0
wait 1
video 1000c0001
wr 000 00000006 f 0
wait 1
video 80003600
set forced_scandoubler 1
wait 1
pin scandoubler 1
video 80000000

// File: build.f
msx_glue_pkg.sv
msx_status_regs.sv
msx_reset_ctrl.sv
msx_sd_activity.sv
msx_tape_ctrl.sv
msx_video_cfg.sv
msx_glue_top.sv
msx_glue_assertions.sv
tb_msx_glue.sv

// File: run_sim.sh
#!/bin/sh
# Compile the MSX glue testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_msx_glue -f build.f \
   || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_msx_glue > sim.log 2>&1 \
   || echo "Simulator exited with an error status" >> sim.log
cat sim.log

# The log decides the result
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0
